// ==== logic/adpcm_host_regs.sv ====
// host register block for the ADPCM voices
// holds code and hold bit per voice, raises int_n on voice 0 samples
`default_nettype none

module adpcm_host_regs
    import adpcm_pkg::*;
#(
    parameter int NUM_CH = 2
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      io_wr,      // one cycle write strobe
    input  wire  [2:0]               io_addr,
    input  wire  [7:0]               io_wdata,
    input  wire                      int_ack,    // host acknowledge
    input  wire                      irq_tick,   // voice 0 sample tick
    output voice_ctrl_t [NUM_CH-1:0] voice_ctrl,
    output logic                     int_n
);

    logic last_tick; // previous irq_tick
    logic tick_rise;

    assign tick_rise = irq_tick && !last_tick;

    // control registers, one per voice
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            voice_ctrl <= '0; // all voices running, code 0
        end else if (io_wr) begin
            for (int k = 0; k < NUM_CH; k++) begin
                if (io_addr == 3'(k)) begin
                    voice_ctrl[k].hold <= io_wdata[7];
                    voice_ctrl[k].code <= io_wdata[3:0];
                end
            end
            // addresses at or above NUM_CH fall through
        end
    end

    // interrupt request from voice 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_tick <= 1'b0;
            int_n     <= 1'b1;
        end else begin
            last_tick <= irq_tick;
            if (int_ack) begin
                int_n <= 1'b1;
            end
            if (tick_rise) begin
                int_n <= 1'b0; // new request beats a same cycle ack
            end
        end
    end

    // an ack with no new request releases the line on the next edge
    ack_releases_int: assert property (
        @(posedge clk) disable iff (rst)
        int_ack && !tick_rise |=> int_n
    ) else $error("int_n still low after int_ack");

endmodule

`default_nettype wire

// ==== logic/adpcm_mixer.sv ====
// voice mixer
// sums all voices on the sample tick and clamps to 13 bits
`default_nettype none

module adpcm_mixer
    import adpcm_pkg::*;
#(
    parameter int NUM_CH = 2
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        tick,    // voice 0 sample moment
    input  voice_sample_t [NUM_CH-1:0] voices,
    output mix_sample_t                snd,
    output logic                       sample   // one cycle after tick
);

    localparam int SW = 12 + $clog2(NUM_CH + 1); // room for the full sum

    localparam logic signed [SW-1:0] MIX_MAX = 4095;
    localparam logic signed [SW-1:0] MIX_MIN = -4096;

    logic signed [SW-1:0] acc;
    mix_sample_t          mix_clamped;

    always_comb begin
        acc = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            acc = acc + {{(SW-12){voices[i][11]}}, voices[i]}; // sign extend
        end
        if (acc > MIX_MAX) begin
            mix_clamped = 13'sd4095;
        end else if (acc < MIX_MIN) begin
            mix_clamped = -13'sd4096;
        end else begin
            mix_clamped = acc[12:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd    <= '0;
            sample <= 1'b0;
        end else begin
            sample <= tick;
            if (tick) begin
                snd <= mix_clamped; // voices already hold the new samples
            end
        end
    end

    strobe_follows_tick: assert property (
        @(posedge clk) disable iff (rst)
        sample |-> $past(tick)
    ) else $error("sample strobe without tick");

endmodule

`default_nettype wire

// ==== logic/adpcm_pkg.sv ====
// ADPCM sound block shared types
// MSM5205 step table and index adjust rules used by RTL and testbench
`default_nettype none

package adpcm_pkg;

    typedef logic        [3:0]  adpcm_code_t;    // bit 3 sign, bits 2..0 magnitude
    typedef logic signed [11:0] voice_sample_t;  // one voice after clamping
    typedef logic signed [12:0] mix_sample_t;    // summed output
    typedef logic        [5:0]  step_index_t;    // 0..STEP_MAX
    typedef logic        [10:0] step_t;          // step value up to 1552
    typedef logic signed [4:0]  index_delta_t;   // -1..+8

    // per voice control as written by the host
    typedef struct packed {
        logic        hold;  // voice reset bit
        adpcm_code_t code;
    } voice_ctrl_t;

    localparam int STEP_MAX = 48;

    // MSM5205 step sizes, roughly 1.1x per entry
    localparam step_t STEP_TABLE [0:STEP_MAX] = '{
          16,   17,   19,   21,   23,   25,   28,   31,
          34,   37,   41,   45,   50,   55,   60,   66,
          73,   80,   88,   97,  107,  118,  130,  143,
         157,  173,  190,  209,  230,  253,  279,  307,
         337,  371,  408,  449,  494,  544,  598,  658,
         724,  796,  876,  963, 1060, 1166, 1282, 1411,
        1552
    };

    // step value for an index, saturates above the table
    function automatic step_t step_size(input step_index_t idx);
        step_t val;
        if (idx > step_index_t'(STEP_MAX)) begin
            val = STEP_TABLE[STEP_MAX];
        end else begin
            val = STEP_TABLE[idx];
        end
        return val;
    endfunction

    // index change from code magnitude
    function automatic index_delta_t index_adjust(input logic [2:0] mag);
        index_delta_t adj;
        case (mag)
            3'd4:    adj = 5'sd2;
            3'd5:    adj = 5'sd4;
            3'd6:    adj = 5'sd6;
            3'd7:    adj = 5'sd8;
            default: adj = -5'sd1; // small codes shrink the step
        endcase
        return adj;
    endfunction

endpackage

`default_nettype wire

// ==== logic/adpcm_sound.sv ====
// dual voice ADPCM sound top level
// host registers, NUM_CH decoder voices and the output mixer
`default_nettype none

module adpcm_sound
    import adpcm_pkg::*;
#(
    parameter int NUM_CH     = 2,   // 1..7
    parameter int SAMPLE_DIV = 48   // 384 kHz / 8 kHz
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         cen384,     // 384 kHz enable
    input  wire         io_wr,
    input  wire  [2:0]  io_addr,
    input  wire  [7:0]  io_wdata,
    input  wire         int_ack,
    output logic        int_n,
    output mix_sample_t snd,
    output logic        sample
);

    voice_ctrl_t   [NUM_CH-1:0] voice_ctrl;
    voice_sample_t [NUM_CH-1:0] voice_snd;
    logic          [NUM_CH-1:0] voice_tick;

    adpcm_host_regs #(
        .NUM_CH     (NUM_CH)
    ) host_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .io_wr      (io_wr),
        .io_addr    (io_addr),
        .io_wdata   (io_wdata),
        .int_ack    (int_ack),
        .irq_tick   (voice_tick[0]),  // interrupt follows voice 0
        .voice_ctrl (voice_ctrl),
        .int_n      (int_n)
    );

    // voices share cen384 so their dividers run in step
    for (genvar i = 0; i < NUM_CH; i++) begin : gen_voice
        adpcm_voice #(
            .SAMPLE_DIV (SAMPLE_DIV)
        ) voice_inst (
            .clk    (clk),
            .rst    (rst),
            .cen    (cen384),
            .ctrl   (voice_ctrl[i]),
            .sound  (voice_snd[i]),
            .tick   (voice_tick[i])
        );
    end

    adpcm_mixer #(
        .NUM_CH (NUM_CH)
    ) mixer_inst (
        .clk    (clk),
        .rst    (rst),
        .tick   (voice_tick[0]), // voice 0 marks the sample moment
        .voices (voice_snd),
        .snd    (snd),
        .sample (sample)
    );

endmodule

`default_nettype wire

// ==== logic/adpcm_voice.sv ====
// one MSM5205 style ADPCM decoder voice
// sample divider on the 384 kHz enable, step index and clamped accumulator
`default_nettype none

module adpcm_voice
    import adpcm_pkg::*;
#(
    parameter int SAMPLE_DIV = 48 // enables per sample
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           cen,    // 384 kHz enable
    input  voice_ctrl_t   ctrl,
    output voice_sample_t sound,
    output logic          tick    // high for the decode cycle
);

    localparam int CW = $clog2(SAMPLE_DIV + 1);

    localparam logic signed [13:0] ACC_MAX = 14'sd2047;
    localparam logic signed [13:0] ACC_MIN = -14'sd2048;

    logic [CW-1:0]      div_cnt;      // counts enables in one sample
    logic               sample_now;   // last enable of the period
    step_index_t        index;
    step_t              step;
    logic [11:0]        delta;        // up to 2910
    logic signed [13:0] sound_ext;
    logic signed [13:0] delta_ext;
    logic signed [13:0] acc_next;
    voice_sample_t      sound_next;
    logic signed [6:0]  index_next;
    step_index_t        index_clamped;

    assign sample_now = cen && (div_cnt == CW'(SAMPLE_DIV - 1));
    assign step       = step_size(index);

    // delta from magnitude bits
    always_comb begin
        delta = 12'(step >> 3); // always step/8
        if (ctrl.code[0]) begin
            delta = delta + 12'(step >> 2);
        end
        if (ctrl.code[1]) begin
            delta = delta + 12'(step >> 1);
        end
        if (ctrl.code[2]) begin
            delta = delta + 12'(step);
        end
    end

    // accumulator update with 12 bit saturation
    always_comb begin
        sound_ext = {{2{sound[11]}}, sound};
        delta_ext = {2'b00, delta};
        if (ctrl.code[3]) begin
            acc_next = sound_ext - delta_ext; // negative code
        end else begin
            acc_next = sound_ext + delta_ext;
        end
        if (acc_next > ACC_MAX) begin
            sound_next = 12'sd2047;
        end else if (acc_next < ACC_MIN) begin
            sound_next = -12'sd2048;
        end else begin
            sound_next = acc_next[11:0];
        end
    end

    // step index walk, kept inside the table
    always_comb begin
        index_next = $signed({1'b0, index}) + 7'(index_adjust(ctrl.code[2:0]));
        if (index_next < 7'sd0) begin
            index_clamped = '0;
        end else if (index_next > STEP_MAX) begin
            index_clamped = step_index_t'(STEP_MAX);
        end else begin
            index_clamped = index_next[5:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            index   <= '0;
            sound   <= '0;
            tick    <= 1'b0;
        end else if (ctrl.hold) begin
            div_cnt <= '0; // held voice restarts its period on release
            index   <= '0;
            sound   <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= sample_now;
            if (cen) begin
                div_cnt <= sample_now ? '0 : div_cnt + 1'b1;
            end
            if (sample_now) begin
                sound <= sound_next;
                index <= index_clamped;
            end
        end
    end

    index_in_table: assert property (
        @(posedge clk) disable iff (rst)
        index <= step_index_t'(STEP_MAX)
    ) else $error("step index beyond table");

    // hold seen on an edge keeps the next cycle free of ticks
    no_tick_in_hold: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.hold |=> !tick
    ) else $error("tick while voice held");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the ADPCM sound testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module adpcm_sound_tb \
    -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vadpcm_sound_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// ==== src.f ====
logic/adpcm_pkg.sv
logic/adpcm_host_regs.sv
logic/adpcm_voice.sv
logic/adpcm_mixer.sv
logic/adpcm_sound.sv
tb/adpcm_sound_tb.sv

// ==== tb/adpcm_sound_tb.sv ====
// testbench for the dual voice ADPCM sound block
// host writes drive both voices, a decoder model predicts snd and int_n
`default_nettype none

module adpcm_sound_tb
    import adpcm_pkg::*;
();

    localparam int          NUM_CH     = 2;
    localparam int          SAMPLE_DIV = 4;   // short periods, 16 clocks per sample
    localparam int          WAIT_LIMIT = 64;  // clocks before a strobe wait gives up
    localparam logic [31:0] SEED       = 32'h95e85b25;

    logic        clk;
    logic        rst;
    logic        cen384;
    logic        io_wr;
    logic [2:0]  io_addr;
    logic [7:0]  io_wdata;
    logic        int_ack;
    logic        int_n;
    mix_sample_t snd;
    logic        sample;

    logic [1:0]  cen_cnt;  // free running enable divider

    // decoder model, one entry per voice
    voice_sample_t m_sound [NUM_CH];
    step_index_t   m_index [NUM_CH];
    adpcm_code_t   m_code  [NUM_CH];
    logic          m_hold  [NUM_CH];
    mix_sample_t   expected_snd;   // value due at the next strobe

    int errors;
    int tests_run;
    int tests_failed;
    bit aborted;                   // set once a wait times out

    adpcm_sound #(
        .NUM_CH     (NUM_CH),
        .SAMPLE_DIV (SAMPLE_DIV)
    ) adpcm_sound_inst (
        .clk      (clk),
        .rst      (rst),
        .cen384   (cen384),
        .io_wr    (io_wr),
        .io_addr  (io_addr),
        .io_wdata (io_wdata),
        .int_ack  (int_ack),
        .int_n    (int_n),
        .snd      (snd),
        .sample   (sample)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cen384 on every 4th clock
    initial begin
        cen_cnt = 2'd0;
        cen384  = 1'b0;
    end

    always @(posedge clk) begin
        #1;
        cen_cnt = cen_cnt + 2'd1;
        cen384  = (cen_cnt == 2'd0);
    end

    snd_matches_model: assert property (
        @(posedge clk) disable iff (rst)
        sample |-> snd == expected_snd
    ) else begin
        errors++;
        $display("Mismatch snd: got %h expected %h", $sampled(snd), $sampled(expected_snd));
    end

    // request and strobe come from the same voice 0 tick
    int_low_at_sample: assert property (
        @(posedge clk) disable iff (rst)
        sample |-> !int_n
    ) else begin
        errors++;
        $display("Mismatch int_n: got %h expected %h at sample strobe", $sampled(int_n), 1'b0);
    end

    ack_releases_int: assert property (
        @(posedge clk) disable iff (rst)
        int_ack |=> int_n || sample   // a new tick in the ack cycle wins
    ) else begin
        errors++;
        $display("Mismatch int_n: got %h expected %h after int_ack", $sampled(int_n), 1'b1);
    end

    // one decode step of voice k with its current code
    function automatic void decode_voice(input int k);
        step_t      step;
        logic [2:0] mag;
        int         delta;
        int         acc;
        int         idx;
        step  = step_size(m_index[k]);
        mag   = m_code[k][2:0];
        delta = step / 8;
        if (mag[0]) delta += step / 4;
        if (mag[1]) delta += step / 2;
        if (mag[2]) delta += step;
        if (m_code[k][3]) acc = int'(m_sound[k]) - delta;  // sign bit set
        else              acc = int'(m_sound[k]) + delta;
        if (acc > 2047)       acc = 2047;
        else if (acc < -2048) acc = -2048;
        m_sound[k] = voice_sample_t'(acc);
        idx = int'(m_index[k]) + int'(index_adjust(mag));
        if (idx < 0)             idx = 0;
        else if (idx > STEP_MAX) idx = STEP_MAX;
        m_index[k] = step_index_t'(idx);
    endfunction

    function automatic mix_sample_t mix_model();
        int sum;
        sum = 0;
        for (int k = 0; k < NUM_CH; k++) begin
            sum += int'(m_sound[k]);
        end
        if (sum > 4095)       sum = 4095;   // 13 bit rails
        else if (sum < -4096) sum = -4096;
        return mix_sample_t'(sum);
    endfunction

    function automatic void check_int(input logic want);
        assert (int_n === want) else begin
            errors++;
            $display("Mismatch int_n: got %h expected %h", int_n, want);
        end
    endfunction

    // advance the model by one sample, held voices stay at zero
    task automatic predict_sample();
        for (int k = 0; k < NUM_CH; k++) begin
            if (!m_hold[k]) decode_voice(k);
        end
        expected_snd = mix_model();
    endtask

    // returns one edge after the strobe, once snd_matches_model has run
    task automatic wait_strobe();
        bit seen;
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && !aborted && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            seen = sample;
            n++;
        end
        if (!seen && !aborted) begin
            $display("timeout: no sample strobe within %0d clocks", WAIT_LIMIT);
            errors++;
            aborted = 1'b1;
        end
        if (seen) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic host_write(input logic [2:0] addr, input logic [7:0] data);
        io_addr  = addr;
        io_wdata = data;
        io_wr    = 1'b1;
        @(posedge clk);
        #1;
        io_wr = 1'b0;
        if (int'(addr) < NUM_CH) begin  // other addresses are dropped
            m_code[addr] = data[3:0];
            m_hold[addr] = data[7];
            if (data[7]) begin
                m_sound[addr] = '0;
                m_index[addr] = '0;
            end
        end
    endtask

    task automatic play_random(input int count, input bit both);
        for (int i = 0; i < count; i++) begin
            if (both) host_write(3'd1, {4'h0, 4'($urandom())});  // voice 1 first keeps phase
            host_write(3'd0, {4'h0, 4'($urandom())});
            predict_sample();
            wait_strobe();
        end
    endtask

    task automatic play_fixed(input int count, input adpcm_code_t code);
        host_write(3'd1, {4'h0, code});
        host_write(3'd0, {4'h0, code});
        for (int i = 0; i < count; i++) begin
            predict_sample();
            wait_strobe();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin : main_seq
        int mark;
        void'($urandom(SEED));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        rst          = 1'b1;
        io_wr        = 1'b0;
        io_addr      = 3'd0;
        io_wdata     = 8'h00;
        int_ack      = 1'b0;
        expected_snd = '0;
        for (int k = 0; k < NUM_CH; k++) begin
            m_sound[k] = '0;
            m_index[k] = '0;
            m_code[k]  = '0;
            m_hold[k]  = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        mark = errors;
        check_int(1'b1);
        assert (sample === 1'b0) else begin
            errors++;
            $display("Mismatch sample: got %h expected %h", sample, 1'b0);
        end
        assert (snd === '0) else begin
            errors++;
            $display("Mismatch snd: got %h expected %h", snd, 13'h0);
        end
        report_test("reset state", mark);

        mark = errors;
        predict_sample();  // first sample decodes code 0 on both voices
        wait_strobe();
        host_write(3'd1, 8'h80);
        play_random(12, 1'b0);
        report_test("voice 0 alone", mark);

        mark = errors;
        play_random(1, 1'b1);     // releases voice 1 in phase with voice 0
        host_write(3'd5, 8'h87);  // no such voice
        play_random(11, 1'b1);
        report_test("both voices", mark);

        mark = errors;
        play_fixed(14, 4'd7);
        assert (snd === 13'sd4094) else begin  // both voices at +2047
            errors++;
            $display("Mismatch snd: got %h expected %h", snd, 13'sd4094);
        end
        play_fixed(6, 4'd15);
        assert (snd === -13'sd4096) else begin  // both voices at -2048
            errors++;
            $display("Mismatch snd: got %h expected %h", snd, -13'sd4096);
        end
        report_test("clamp rails", mark);

        mark = errors;
        host_write(3'd1, 8'h80);
        play_random(3, 1'b0);
        play_random(8, 1'b1);     // release gives a fresh decoder
        report_test("hold and release", mark);

        mark = errors;
        predict_sample();
        wait_strobe();
        check_int(1'b0);
        repeat (4) begin          // nothing clears the request yet
            @(posedge clk);
            #1;
            check_int(1'b0);
        end
        int_ack = 1'b1;
        @(posedge clk);
        #1;
        int_ack = 1'b0;
        check_int(1'b1);
        predict_sample();
        wait_strobe();
        check_int(1'b0);
        report_test("interrupt", mark);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
